/* snes_host_macros.svh */
// snes host constants
// bridge register map, data-table word indices, core reset hold
// length and the depth of the controller synchronizers

`ifndef SNES_HOST_MACROS_SVH
`define SNES_HOST_MACROS_SVH

//////////////////////////////
// bridge write addresses
//////////////////////////////

`define SNES_REG_DOWNLOAD      32'h0000_0000
`define SNES_REG_RESET         32'h0000_0050
`define SNES_REG_MULTITAP      32'h0000_0100
`define SNES_REG_LIGHTGUN      32'h0000_0104
`define SNES_REG_AIM_SPEED     32'h0000_0108
`define SNES_REG_VIDEO         32'h0000_0200

//////////////////////////////
// host data table
//////////////////////////////

// word indices, not slot ids
`define SNES_DT_ROM_SIZE_ADDR  10'd1
`define SNES_DT_SAVE_SIZE_ADDR 10'd3
`define SNES_SAVE_SIZE_BASE    32'd1024

`define SNES_RESET_HOLD_DEFAULT 32'h0010_0000
`define SNES_SYNC_STAGES        3

`endif

/* snes_host_pkg.sv */
// snes host shared types
// register select and sequencer enums, settings, pad, video
// and data-table request structs

`default_nettype none

package snes_host_pkg;

  // register picked by a bridge write
  typedef enum logic [2:0] {
    reg_none,
    reg_download,
    reg_reset,
    reg_multitap,
    reg_lightgun,
    reg_aim_speed,
    reg_video
  } host_reg_e;

  // what the data-table sequencer does in a phase
  typedef enum logic [0:0] {
    dt_read_rom_size,
    dt_write_save_size
  } dt_action_e;

  typedef struct packed {
    logic       download;
    logic       multitap_enabled;
    logic       lightgun_enabled;
    logic       lightgun_type;
    logic [7:0] aim_speed;
    logic       use_4_3_video;
  } core_settings_t;

  // keys use the controller bitmap, dpad in [3:0], start in [15]
  typedef struct packed {
    logic [15:0] keys;
    logic [7:0]  stick_x;
    logic [7:0]  stick_y;
  } pad_t;

  typedef pad_t [3:0] pad_array_t;

  typedef struct packed {
    logic        hblank;
    logic        vblank;
    logic        hsync;
    logic        vsync;
    logic [23:0] rgb;
  } video_in_t;

  typedef struct packed {
    logic        de;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } video_out_t;

  typedef struct packed {
    logic [9:0]  addr;
    logic        wren;
    logic [31:0] data;
  } datatable_req_t;

endpackage

`default_nettype wire

/* host_settings_regs.sv */
// host settings registers
// decodes bridge writes into the core settings and stretches
// a reset register write into a long core reset

`timescale 1ns/1ps
`default_nettype none

`include "snes_host_macros.svh"

module host_settings_regs
  import snes_host_pkg::*;
#(
  parameter int unsigned reset_hold = `SNES_RESET_HOLD_DEFAULT
) (
  input  wire             clk_74a,
  input  wire             pll_core_locked,
  input  wire             bridge_wr,
  input  wire      [31:0] bridge_addr,
  input  wire      [31:0] bridge_wr_data,
  output core_settings_t  settings,
  output logic            core_reset
);

  host_reg_e   reg_sel;
  logic [31:0] reset_count;

  //////////////////////////////
  // address decode
  //////////////////////////////

  always_comb begin
    reg_sel = reg_none;
    if (bridge_wr) begin
      case (bridge_addr)
        `SNES_REG_DOWNLOAD:  reg_sel = reg_download;
        `SNES_REG_RESET:     reg_sel = reg_reset;
        `SNES_REG_MULTITAP:  reg_sel = reg_multitap;
        `SNES_REG_LIGHTGUN:  reg_sel = reg_lightgun;
        `SNES_REG_AIM_SPEED: reg_sel = reg_aim_speed;
        `SNES_REG_VIDEO:     reg_sel = reg_video;
        default:             reg_sel = reg_none;
      endcase
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings    <= '0;
      reset_count <= '0;
    end else begin
      if (reset_count != 0) begin
        reset_count <= reset_count - 32'd1;
      end
      case (reg_sel)
        reg_download:  settings.download <= bridge_wr_data[0];
        // a rewrite restarts the hold
        reg_reset:     reset_count <= 32'(reset_hold);
        reg_multitap:  settings.multitap_enabled <= bridge_wr_data[0];
        reg_lightgun: begin
          settings.lightgun_enabled <= bridge_wr_data[0];
          settings.lightgun_type    <= bridge_wr_data[1];
        end
        reg_aim_speed: settings.aim_speed <= bridge_wr_data[7:0];
        reg_video:     settings.use_4_3_video <= bridge_wr_data[0];
        default: ;
      endcase
    end
  end

  // held while the pll is out of lock too
  assign core_reset = !pll_core_locked || (reset_count != 0);

  // every mapped address lands on a register
  assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    bridge_wr && (bridge_addr inside {`SNES_REG_DOWNLOAD, `SNES_REG_RESET,
      `SNES_REG_MULTITAP, `SNES_REG_LIGHTGUN, `SNES_REG_AIM_SPEED,
      `SNES_REG_VIDEO}) |-> reg_sel != reg_none);

endmodule

`default_nettype wire

/* data_slot_manager.sv */
// data slot manager
// eight-phase sequencer that reads the rom size from the host
// data table and writes back the save size, plus the save flag

`timescale 1ns/1ps
`default_nettype none

`include "snes_host_macros.svh"

module data_slot_manager
  import snes_host_pkg::*;
(
  input  wire             clk_74a,
  input  wire             pll_core_locked,
  input  wire      [3:0]  sram_size,
  input  wire      [31:0] datatable_q,
  input  wire             dataslot_requestread,
  input  wire             dataslot_requestwrite,
  input  wire             dataslot_allcomplete,
  output datatable_req_t  datatable_req,
  output logic     [31:0] rom_file_size,
  output logic            save_download
);

  logic [2:0]  phase;
  dt_action_e  action;
  logic [31:0] save_size;
  logic        allcomplete_prev;

  //////////////////////////////
  // data-table sequencer
  //////////////////////////////

  // upper three phases write, the rest read
  assign action = (phase > 3'd4) ? dt_write_save_size : dt_read_rom_size;

  // size code 0 means no cartridge sram
  assign save_size = (sram_size != 4'd0) ? (`SNES_SAVE_SIZE_BASE << sram_size) : 32'd0;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase         <= '0;
      datatable_req <= '0;
      rom_file_size <= '0;
    end else begin
      phase <= phase + 3'd1;
      if (action == dt_write_save_size) begin
        datatable_req.wren <= 1'b1;
        datatable_req.addr <= `SNES_DT_SAVE_SIZE_ADDR;
        datatable_req.data <= save_size;
      end else begin
        datatable_req.wren <= 1'b0;
        datatable_req.addr <= `SNES_DT_ROM_SIZE_ADDR;
        // read address has been stable for several cycles here
        if (phase == 3'd4) begin
          rom_file_size <= datatable_q;
        end
      end
    end
  end

  //////////////////////////////
  // save transfer flag
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      save_download    <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_download <= 1'b1;
      end else if (dataslot_allcomplete && !allcomplete_prev) begin
        save_download <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    datatable_req.wren |-> datatable_req.addr == `SNES_DT_SAVE_SIZE_ADDR);

endmodule

`default_nettype wire

/* pad_synchronizer.sv */
// controller synchronizer
// carries one controller's keys and left stick through a short
// register chain into the clk_74a domain

`timescale 1ns/1ps
`default_nettype none

`include "snes_host_macros.svh"

module pad_synchronizer
  import snes_host_pkg::*;
(
  input  wire         clk_74a,
  input  wire         pll_core_locked,
  input  wire  [15:0] key,
  input  wire  [31:0] joy,
  output pad_t        pad
);

  pad_t [`SNES_SYNC_STAGES-1:0] sync_q;
  pad_t                         pad_in;

  // left stick only, right stick bytes in joy[31:16] are dropped
  assign pad_in = '{keys: key, stick_x: joy[7:0], stick_y: joy[15:8]};

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`SNES_SYNC_STAGES-2:0], pad_in};
    end
  end

  // last stage of the chain
  assign pad = sync_q[`SNES_SYNC_STAGES-1];

endmodule

`default_nettype wire

/* video_formatter.sv */
// video formatter
// turns emulator blanking and syncs into scaler video with
// data enable, single-cycle sync pulses and the end-of-line
// slot word carrying the pal and 4:3 flags

`timescale 1ns/1ps
`default_nettype none

module video_formatter
  import snes_host_pkg::*;
(
  input  wire        clk_74a,
  input  wire        pll_core_locked,
  input  video_in_t  video_in,
  input  wire        pal,
  input  wire        use_4_3_video,
  output video_out_t video_out
);

  logic        de;
  logic        de_prev;
  logic        hs_prev;
  logic        vs_prev;
  logic [23:0] slot_word;

  // active area is anywhere outside both blanks
  assign de = !(video_in.hblank || video_in.vblank);

  // pal in bit 14, 4:3 flag in bit 13
  assign slot_word = {9'b0, pal, use_4_3_video, 13'b0};

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_out <= '0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_out.de <= de;

      if (de) begin
        video_out.rgb <= video_in.rgb;
      end else if (de_prev) begin
        // first blank cycle after the last pixel
        video_out.rgb <= slot_word;
      end else begin
        video_out.rgb <= 24'h0;
      end

      // single-cycle pulse on each sync rise
      video_out.hs <= video_in.hsync && !hs_prev;
      video_out.vs <= video_in.vsync && !vs_prev;

      de_prev <= de;
      hs_prev <= video_in.hsync;
      vs_prev <= video_in.vsync;
    end
  end

  assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.hs |=> !video_out.hs);

endmodule

`default_nettype wire

/* snes_host_top.sv */
// snes host top level
// joins the settings registers, data-slot manager, controller
// synchronizers and video formatter around the emulator core

`timescale 1ns/1ps
`default_nettype none

`include "snes_host_macros.svh"

module snes_host_top
  import snes_host_pkg::*;
#(
  parameter int unsigned reset_hold = `SNES_RESET_HOLD_DEFAULT
) (
  input  wire                  clk_74a,
  input  wire                  pll_core_locked,

  // bridge writes
  input  wire                  bridge_wr,
  input  wire       [31:0]     bridge_addr,
  input  wire       [31:0]     bridge_wr_data,

  // host data table and slots
  input  wire       [3:0]      sram_size,
  input  wire       [31:0]     datatable_q,
  input  wire                  dataslot_requestread,
  input  wire                  dataslot_requestwrite,
  input  wire                  dataslot_allcomplete,

  // controllers, index 0 is player 1
  input  wire       [3:0][15:0] cont_key,
  input  wire       [3:0][31:0] cont_joy,

  input  video_in_t            video_in,
  input  wire                  pal,

  output core_settings_t       settings,
  output logic                 core_reset,
  output datatable_req_t       datatable_req,
  output logic      [31:0]     rom_file_size,
  output logic                 save_download,
  output pad_array_t           pads,
  output video_out_t           video_out
);

  //////////////////////////////
  // host housekeeping
  //////////////////////////////

  host_settings_regs #(
    .reset_hold(reset_hold)
  ) u_settings (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .settings       (settings),
    .core_reset     (core_reset)
  );

  data_slot_manager u_data_slot (
    .clk_74a              (clk_74a),
    .pll_core_locked      (pll_core_locked),
    .sram_size            (sram_size),
    .datatable_q          (datatable_q),
    .dataslot_requestread (dataslot_requestread),
    .dataslot_requestwrite(dataslot_requestwrite),
    .dataslot_allcomplete (dataslot_allcomplete),
    .datatable_req        (datatable_req),
    .rom_file_size        (rom_file_size),
    .save_download        (save_download)
  );

  //////////////////////////////
  // controllers
  //////////////////////////////

  for (genvar i = 0; i < 4; i++) begin : g_pad
    pad_synchronizer u_pad (
      .clk_74a        (clk_74a),
      .pll_core_locked(pll_core_locked),
      .key            (cont_key[i]),
      .joy            (cont_joy[i]),
      .pad            (pads[i])
    );
  end

  // scaler video, one pixel per clk_74a
  video_formatter u_video (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .video_in       (video_in),
    .pal            (pal),
    .use_4_3_video  (settings.use_4_3_video),
    .video_out      (video_out)
  );

endmodule

`default_nettype wire

/* tb_snes_host_checks.svh */
// snes host testbench checks
// value check, test names and the reference models for the
// pad path and the video formatter

`ifndef TB_SNES_HOST_CHECKS_SVH
`define TB_SNES_HOST_CHECKS_SVH

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
  checks++;
  assert (got === expected) else begin
    $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
    errors++;
  end
endtask

function automatic string kind_name(input logic [31:0] kind);
  case (kind)
    1: return "settings write";
    2: return "reset stretch";
    3: return "data-table cycle";
    4: return "save flag";
    5: return "pad path";
    6: return "video line";
    default: return "unknown";
  endcase
endfunction

// left stick is joy[15:0], right stick bytes never reach the pad
function automatic pad_t expected_pad(input logic [15:0] key, input logic [31:0] joy);
  pad_t p;
  p.keys = key;
  p.stick_x = joy[7:0];
  p.stick_y = joy[15:8];
  return p;
endfunction

// one output word from the current and previous input cycle
function automatic video_out_t predict_video(input video_in_t cur, input video_in_t prev,
                                             input logic [23:0] slot);
  video_out_t v;
  logic cur_active;
  logic prev_active;
  cur_active = !cur.hblank && !cur.vblank;
  prev_active = !prev.hblank && !prev.vblank;
  v.de = cur_active;
  v.hs = cur.hsync && !prev.hsync;
  v.vs = cur.vsync && !prev.vsync;
  if (cur_active)
    v.rgb = cur.rgb;
  else if (prev_active)
    v.rgb = slot;
  else
    v.rgb = 24'h0;
  return v;
endfunction

`endif

/* tb_snes_host.sv */
// snes host testbench
// replays the trace records against the DUT, one behavior per
// record, and checks the responses against the trace values

`timescale 1ns/1ps
`default_nettype none

module tb_snes_host
  import snes_host_pkg::*;
();

  localparam int max_records = 64;
  localparam int clk_period = 8;

  logic             clk_74a;
  logic             pll_core_locked;
  logic             bridge_wr;
  logic [31:0]      bridge_addr;
  logic [31:0]      bridge_wr_data;
  logic [3:0]       sram_size;
  logic [31:0]      datatable_q;
  logic             dataslot_requestread;
  logic             dataslot_requestwrite;
  logic             dataslot_allcomplete;
  logic [3:0][15:0] cont_key;
  logic [3:0][31:0] cont_joy;
  video_in_t        video_in;
  logic             pal;
  core_settings_t   settings;
  logic             core_reset;
  datatable_req_t   datatable_req;
  logic [31:0]      rom_file_size;
  logic             save_download;
  pad_array_t       pads;
  video_out_t       video_out;

  // four words per record: kind, addr or code, data, expected
  logic [31:0] trace_mem [0:4*max_records-1];
  int          num_tests;
  int          errors;
  int          checks;
  int          tests_failed;
  logic        trace_loaded;

  snes_host_top #(.reset_hold(20)) DUT (.*);

  always #(clk_period / 2) clk_74a = ~clk_74a;

  `include "tb_snes_host_checks.svh"

  //////////////////////////////
  // behavior tests
  //////////////////////////////

  task automatic settings_write_test(input logic [31:0] addr, input logic [31:0] data,
                                     input logic [31:0] expected);
    @(negedge clk_74a);
    bridge_wr = 1'b1;
    bridge_addr = addr;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
    check_value("settings", 32'(settings), expected);
  endtask

  task automatic reset_stretch_test(input logic [31:0] addr, input logic [31:0] expected);
    int high_cycles;
    @(negedge clk_74a);
    check_value("core_reset", core_reset, 0);
    bridge_wr = 1'b1;
    bridge_addr = addr;
    bridge_wr_data = '0;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
    high_cycles = 0;
    while (core_reset && high_cycles <= expected + 8) begin
      high_cycles++;
      @(negedge clk_74a);
    end
    check_value("core_reset high cycles", high_cycles, expected);
  endtask

  task automatic datatable_test(input logic [3:0] code, input logic [31:0] q,
                                input logic [31:0] expected);
    int waited;
    @(negedge clk_74a);
    sram_size = code;
    // the inverse everywhere except the cycle sampled at phase 4
    datatable_q = ~q;
    waited = 0;
    // align to the first write of a period
    while (datatable_req.wren && waited < 16) begin
      @(negedge clk_74a);
      waited++;
    end
    while (!datatable_req.wren && waited < 16) begin
      @(negedge clk_74a);
      waited++;
    end
    if (!datatable_req.wren) begin
      $display("data-table write phase never seen within 16 cycles");
      errors++;
    end else begin
      for (int k = 0; k < 16; k++) begin
        check_value("datatable_req.wren", datatable_req.wren, (k % 8) < 3);
        check_value("datatable_req.addr", datatable_req.addr, ((k % 8) < 3) ? 3 : 1);
        if ((k % 8) < 3)
          check_value("datatable_req.data", datatable_req.data, expected);
        // next edge handles phase (k + 6) mod 8
        datatable_q = ((k % 8) == 6) ? q : ~q;
        @(negedge clk_74a);
      end
      check_value("rom_file_size", rom_file_size, q);
    end
  endtask

  task automatic save_flag_test(input logic use_write, input logic expected);
    @(negedge clk_74a);
    dataslot_requestread = !use_write;
    dataslot_requestwrite = use_write;
    @(negedge clk_74a);
    dataslot_requestread = 1'b0;
    dataslot_requestwrite = 1'b0;
    check_value("save_download", save_download, expected);
    @(negedge clk_74a);
    check_value("save_download", save_download, expected);
    dataslot_allcomplete = 1'b1;
    // cleared by the edge, and stays clear while held
    repeat (4) begin
      @(negedge clk_74a);
      check_value("save_download", save_download, 0);
    end
    dataslot_allcomplete = 1'b0;
  endtask

  task automatic pad_path_test(input int count, input int latency);
    pad_array_t history [0:max_records-1];
    for (int i = 0; i < count + latency; i++) begin
      @(negedge clk_74a);
      if (i >= latency) begin
        for (int p = 0; p < 4; p++)
          check_value($sformatf("pads[%0d]", p), pads[p], history[i - latency][p]);
      end
      if (i < count) begin
        for (int p = 0; p < 4; p++) begin
          cont_key[p] = 16'($urandom);
          cont_joy[p] = $urandom;
          history[i][p] = expected_pad(cont_key[p], cont_joy[p]);
        end
      end
    end
  endtask

  task automatic video_line_test(input logic pal_in, input int pixels,
                                 input logic [23:0] slot);
    video_in_t  idle;
    video_in_t  prev;
    video_in_t  cur;
    video_out_t expected;
    int         len;
    idle = '0;
    idle.hblank = 1'b1;
    idle.vblank = 1'b1;
    prev = idle;
    len = pixels + 8;
    for (int k = 0; k <= len; k++) begin
      @(negedge clk_74a);
      if (k > 0) begin
        check_value("video_out.de", video_out.de, expected.de);
        check_value("video_out.hs", video_out.hs, expected.hs);
        check_value("video_out.vs", video_out.vs, expected.vs);
        check_value("video_out.rgb", video_out.rgb, expected.rgb);
      end
      if (k < len) begin
        cur = '0;
        // vblank alone blanks cycles 2 and 3
        cur.hblank = (k < 2) || (k >= 4 + pixels);
        cur.vblank = (k < 4);
        cur.hsync = (k == 1) || (k == 2);
        cur.vsync = (k == len - 3) || (k == len - 2);
        cur.rgb = 24'($urandom);
        pal = pal_in;
        video_in = cur;
        expected = predict_video(cur, prev, slot);
        prev = cur;
      end else begin
        video_in = idle;
      end
    end
  endtask

  task automatic run_record(input logic [31:0] kind, input logic [31:0] arg,
                            input logic [31:0] data, input logic [31:0] expected);
    case (kind)
      1: settings_write_test(arg, data, expected);
      2: reset_stretch_test(arg, expected);
      3: datatable_test(arg[3:0], data, expected);
      4: save_flag_test(arg[0], expected[0]);
      5: pad_path_test(arg, expected);
      6: video_line_test(arg[0], data, expected[23:0]);
      default: ;
    endcase
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : main
    int errors_before;
    void'($urandom(32'h955bf4e3));
    clk_74a = 1'b0;
    pll_core_locked = 1'b0;
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    sram_size = '0;
    datatable_q = '0;
    dataslot_requestread = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete = 1'b0;
    cont_key = '0;
    cont_joy = '0;
    video_in = '0;
    video_in.hblank = 1'b1;
    video_in.vblank = 1'b1;
    pal = 1'b0;
    errors = 0;
    checks = 0;
    tests_failed = 0;
    num_tests = 0;
    trace_loaded = 1'b0;

    $readmemh("snes_host_trace.txt", trace_mem);
    while (num_tests < max_records && trace_mem[4*num_tests] >= 1 &&
           trace_mem[4*num_tests] <= 6)
      num_tests++;
    trace_loaded = 1'b1;

    repeat (3) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;

    if (num_tests == 0) begin
      $display("no trace records could be read from snes_host_trace.txt");
      errors++;
    end
    for (int t = 0; t < num_tests; t++) begin
      errors_before = errors;
      run_record(trace_mem[4*t], trace_mem[4*t+1], trace_mem[4*t+2], trace_mem[4*t+3]);
      if (errors != errors_before)
        tests_failed++;
      $display("test %0d %s: %s", t, kind_name(trace_mem[4*t]),
               (errors == errors_before) ? "pass" : "fail");
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             num_tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // 200 cycles per trace record, one extra for reset
  initial begin : watchdog
    wait (trace_loaded === 1'b1);
    #((num_tests + 1) * 200 * clk_period);
    $display("watchdog expired before the trace was finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* snes_host_trace.txt */
// one test per line, hex fields: kind addr_or_code data expected
// kinds 1 settings, 2 reset stretch, 3 data table, 4 save flag, 5 pads, 6 video
1 00000000 00000001 00001000
1 00000100 00000001 00001800
1 00000104 00000003 00001e00
1 00000108 000000a5 00001f4a
1 00000200 00000001 00001f4b
1 00000300 ffffffff 00001f4b
1 00000000 00000000 00000f4b
2 00000050 00000000 00000014
3 00000005 12345678 00008000
3 00000000 cafef00d 00000000
3 0000000f 0badbeef 02000000
4 00000000 00000000 00000001
4 00000001 00000000 00000001
5 0000000c 00000000 00000003
6 00000001 00000006 00006000
6 00000000 0000000a 00002000

/* snes_host.f */
+incdir+.
snes_host_pkg.sv
host_settings_regs.sv
data_slot_manager.sv
pad_synchronizer.sv
video_formatter.sv
snes_host_top.sv
tb_snes_host.sv
